/* bench/memory_control_checker.sv */
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// memory controller checker
// concurrent assertions on the RAM port and the core wait rules
// ----------------------------------------------------------------------
module memory_control_checker (
  input logic                            CLK,
  input logic                            nRST,
  input coherence_pkg::ram_req_t         ram_req,
  input coherence_pkg::core_resp_t [1:0] core_resp,
  input coherence_pkg::ctrl_state_t      cstate
);

  ram_dir_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(ram_req.ramREN && ram_req.ramWEN))
    else $error("RAM read and write requested together");

  core0_one_wait: assert property (@(posedge CLK) disable iff (!nRST)
    core_resp[0].iwait || core_resp[0].dwait)
    else $error("core 0 has both waits low");

  core1_one_wait: assert property (@(posedge CLK) disable iff (!nRST)
    core_resp[1].iwait || core_resp[1].dwait)
    else $error("core 1 has both waits low");

  // nothing is served while a halted core flushes
  halt_holds: assert property (@(posedge CLK) disable iff (!nRST)
    (cstate == coherence_pkg::HALT) |->
      (core_resp[0].iwait && core_resp[0].dwait && core_resp[1].iwait && core_resp[1].dwait))
    else $error("a wait dropped during HALT");

endmodule

bind memory_control memory_control_checker i_memory_control_checker (
  .CLK       (CLK),
  .nRST      (nRST),
  .ram_req   (ram_req),
  .core_resp (core_resp),
  .cstate    (cstate)
);
`default_nettype wire

/* bench/memory_control_tb.sv */
`timescale 1ns/1ns
`default_nettype none
// ----------------------------------------------------------------------
// coherent memory testbench
// plays both cores and caches with random traffic and checks loads,
// snoop outputs and halt behavior against a reference memory
// ----------------------------------------------------------------------
module memory_control_tb;

  localparam int  N_TXN       = 200;
  localparam int  CLK_PERIOD  = 4;
  localparam int  WAIT_LIMIT  = 40;
  localparam time WATCHDOG_NS = (N_TXN * 20 + 16) * CLK_PERIOD;

  logic                            CLK;
  logic                            nRST;
  coherence_pkg::core_req_t [1:0]  core_req;
  coherence_pkg::cc_in_t [1:0]     cc_in;
  coherence_pkg::core_resp_t [1:0] core_resp;
  coherence_pkg::cc_out_t [1:0]    cc_out;

  coherence_pkg::word_t ref_mem [256];
  logic                 cvalid [2][16];
  logic                 cdirty [2][16];
  coherence_pkg::word_t cdata [2][16];
  integer               seed;

  coherent_memory_top #(
    .RAM_LATENCY (3)
  ) i_coherent_memory_top (
    .CLK       (CLK),
    .nRST      (nRST),
    .core_req  (core_req),
    .cc_in     (cc_in),
    .core_resp (core_resp),
    .cc_out    (cc_out)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all transactions finished");
    $display("Test failures found");
    $fatal(1, "run timed out");
  end

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input coherence_pkg::word_t exp,
                            input coherence_pkg::word_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_snoop(input string name, input coherence_pkg::cc_out_t exp,
                             input coherence_pkg::cc_out_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_ram_idle(input string name, input coherence_pkg::ram_req_t act);
    if (act.ramREN !== 1'b0 || act.ramWEN !== 1'b0) begin
      $display("[FAIL] %s expected REN/WEN 00 actual %b%b", name, act.ramREN, act.ramWEN);
      stop_run();
    end
  endtask

  // expected snoop outputs of one core from the other core's reply
  function automatic coherence_pkg::cc_out_t expect_snoop(input logic hold,
      input coherence_pkg::addr_t addr, input coherence_pkg::cc_in_t other);
    coherence_pkg::cc_out_t e;
    e.ccwait      = hold;
    e.ccinv       = other.cctrans & other.ccwrite;
    e.ccsnoopaddr = addr;
    return e;
  endfunction

  function automatic coherence_pkg::addr_t word_addr(input logic [3:0] idx);
    return {26'd0, idx, 2'b00};
  endfunction

  task automatic check_all_waits(input string name);
    for (int i = 0; i < 2; i++) begin
      check_bit(name, 1'b1, core_resp[i].iwait);
      check_bit(name, 1'b1, core_resp[i].dwait);
    end
  endtask

  task automatic await_ready(input int c, input bit instr);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
      check_bit("peer waits held", 1'b1, core_resp[1 - c].iwait & core_resp[1 - c].dwait);
      if (n > WAIT_LIMIT) begin
        $display("core %0d never saw its wait drop", c);
        stop_run();
      end
    end while (instr ? core_resp[c].iwait : core_resp[c].dwait);
  endtask

  task automatic fetch_instr(input int c, input logic [3:0] idx);
    coherence_pkg::core_req_t r;
    coherence_pkg::cc_in_t    ci [2];
    r       = '0;
    r.iREN  = 1'b1;
    r.iaddr = word_addr(idx);
    for (int i = 0; i < 2; i++) begin
      ci[i] = 2'($unsigned($random(seed)));
    end
    @(posedge CLK);
    core_req[c] <= r;
    cc_in[0]    <= ci[0];
    cc_in[1]    <= ci[1];
    await_ready(c, 1'b1);
    check_word("instruction fetch", ref_mem[idx], core_resp[c].iload);
    for (int i = 0; i < 2; i++) begin
      check_snoop("snoop during fetch", expect_snoop(1'b0, '0, ci[1 - i]), cc_out[i]);
    end
    @(posedge CLK);
    core_req[c] <= '0;
  endtask

  task automatic read_data(input int c, input logic [3:0] idx);
    int                       p;
    coherence_pkg::core_req_t r;
    coherence_pkg::core_req_t pr;
    coherence_pkg::cc_in_t    own;
    coherence_pkg::cc_in_t    peer_in;
    coherence_pkg::word_t     exp;
    p               = 1 - c;
    r               = '0;
    r.dREN          = 1'b1;
    r.daddr         = word_addr(idx);
    pr              = '0;
    pr.dstore       = cdata[p][idx];
    own             = 2'($unsigned($random(seed)));
    peer_in.cctrans = cvalid[p][idx];
    peer_in.ccwrite = cvalid[p][idx] & cdirty[p][idx];
    @(posedge CLK);
    core_req[c] <= r;
    core_req[p] <= pr;
    cc_in[c]    <= own;
    cc_in[p]    <= peer_in;
    await_ready(c, 1'b0);
    exp = cvalid[p][idx] ? cdata[p][idx] : ref_mem[idx];
    check_word("data read", exp, core_resp[c].dload);
    check_snoop("peer snoop", expect_snoop(cvalid[p][idx], r.daddr, own), cc_out[p]);
    check_snoop("requester snoop", expect_snoop(1'b0, '0, peer_in), cc_out[c]);
    // a dirty peer line has gone to RAM on the way
    if (peer_in.ccwrite) begin
      ref_mem[idx]   = cdata[p][idx];
      cdirty[p][idx] = 1'b0;
    end
    cvalid[c][idx] = 1'b1;
    cdirty[c][idx] = 1'b0;
    cdata[c][idx]  = exp;
    @(posedge CLK);
    core_req[c] <= '0;
    core_req[p] <= '0;
  endtask

  task automatic write_data(input int c, input logic [3:0] idx);
    int                       p;
    coherence_pkg::core_req_t r;
    coherence_pkg::cc_in_t    peer_in;
    p               = 1 - c;
    r               = '0;
    r.dWEN          = 1'b1;
    r.daddr         = word_addr(idx);
    r.dstore        = $random(seed);
    peer_in.cctrans = cvalid[p][idx];
    peer_in.ccwrite = cvalid[p][idx] & cdirty[p][idx];
    @(posedge CLK);
    core_req[c] <= r;
    cc_in[c]    <= '0;
    cc_in[p]    <= peer_in;
    await_ready(c, 1'b0);
    check_snoop("peer snoop on write", expect_snoop(1'b0, r.daddr, '0), cc_out[p]);
    ref_mem[idx]   = r.dstore;
    cvalid[p][idx] = 1'b0;
    cvalid[c][idx] = 1'b1;
    cdirty[c][idx] = 1'b0;
    cdata[c][idx]  = r.dstore;
    @(posedge CLK);
    core_req[c] <= '0;
  endtask

  // local store hit without bus traffic
  task automatic dirty_local(input int c, input logic [3:0] idx);
    cvalid[c][idx]     = 1'b1;
    cdirty[c][idx]     = 1'b1;
    cdata[c][idx]      = $random(seed);
    cvalid[1 - c][idx] = 1'b0;
  endtask

  task automatic halt_and_flush(input logic [3:0] idx);
    coherence_pkg::core_req_t h;
    coherence_pkg::core_req_t r;
    h        = '0;
    h.halted = 1'b1;
    r        = '0;
    r.dREN   = 1'b1;
    r.daddr  = word_addr(idx);
    @(posedge CLK);
    core_req[0] <= h;
    core_req[1] <= r;
    cc_in       <= '0;
    repeat (10) begin
      @(negedge CLK);
      check_all_waits("waits during halt");
    end
    @(posedge CLK);
    core_req[0].flushed <= 1'b1;
    await_ready(1, 1'b0);
    check_word("read after flush", ref_mem[idx], core_resp[1].dload);
    for (int i = 0; i < 16; i++) begin
      cvalid[0][i] = 1'b0;
    end
    cvalid[1][idx] = 1'b1;
    cdirty[1][idx] = 1'b0;
    cdata[1][idx]  = ref_mem[idx];
    @(posedge CLK);
    core_req[0] <= '0;
    core_req[1] <= '0;
  endtask

  initial begin
    logic [31:0] r;
    int          c;
    seed     = 32'h7a17;
    nRST     = 1'b0;
    core_req = '0;
    cc_in    = '0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = coherence_pkg::word_t'(i);
    end
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < 16; i++) begin
        cvalid[k][i] = 1'b0;
        cdirty[k][i] = 1'b0;
        cdata[k][i]  = '0;
      end
    end
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    repeat (4) begin
      @(negedge CLK);
      check_all_waits("waits after reset");
      check_ram_idle("RAM after reset", i_coherent_memory_top.ram_req);
    end

    for (int t = 0; t < N_TXN; t++) begin
      r = $random(seed);
      c = int'(r[3]);
      if (t % 50 == 49) begin
        halt_and_flush(r[7:4]);
      end else begin
        case (r[2:0])
          3'd0, 3'd1: fetch_instr(c, r[7:4]);
          3'd2, 3'd3: read_data(c, r[7:4]);
          3'd4: begin
            write_data(c, r[7:4]);
            if (r[8]) begin
              read_data(c, r[7:4]);
            end
          end
          3'd5: begin
            dirty_local(c, r[7:4]);
            read_data(1 - c, r[7:4]);
          end
          default: begin
            read_data(c, r[7:4]);
            read_data(1 - c, r[7:4]);
          end
        endcase
      end
    end

    repeat (3) @(negedge CLK);
    check_ram_idle("RAM at end", i_coherent_memory_top.ram_req);
    $display("All tests passed!");
    $finish;
  end

endmodule
`default_nettype wire

/* rtl/coherence_pkg.sv */
`default_nettype none
// --------------------------------------------------------------------
// coherence types
// words, core request and response bundles, snoop signals, the RAM
// port and the coherence FSM states shared across the subsystem
// --------------------------------------------------------------------
package coherence_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  typedef enum logic [1:0] {FREE, BUSY, ACCESS, ERROR} ramstate_t;

  typedef struct packed {
    logic  iREN;
    logic  dREN;
    logic  dWEN;
    addr_t iaddr;
    addr_t daddr;
    word_t dstore;
    logic  halted;
    logic  flushed;
    logic  evict;
  } core_req_t;

  typedef struct packed {
    logic  iwait;
    logic  dwait;
    word_t iload;
    word_t dload;
  } core_resp_t;

  // snoop reply from a cache
  typedef struct packed {
    logic cctrans;
    logic ccwrite;
  } cc_in_t;

  typedef struct packed {
    logic  ccwait;
    logic  ccinv;
    addr_t ccsnoopaddr;
  } cc_out_t;

  typedef struct packed {
    logic  ramREN;
    logic  ramWEN;
    addr_t ramaddr;
    word_t ramstore;
  } ram_req_t;

  typedef enum logic [3:0] {
    IDLE, ARBITER, SNOOP, EVICTION, WRITE_BACK_0, WRITE_BACK_1,
    FETCH_CACHE_0, FETCH_CACHE_1, MISS_0, MISS_1, HALT
  } ctrl_state_t;

endpackage
`default_nettype wire

/* rtl/coherent_memory_top.sv */
`timescale 1ns/1ns
`default_nettype none
// --------------------------------------------------------------------
// coherent memory subsystem
// two core ports sharing one RAM through the coherence controller,
// with snoop routing to the peer caches
// --------------------------------------------------------------------
module coherent_memory_top #(
  parameter int RAM_LATENCY = 2
) (
  input  logic                            CLK,
  input  logic                            nRST,
  input  coherence_pkg::core_req_t [1:0]  core_req,
  input  coherence_pkg::cc_in_t [1:0]     cc_in,
  output coherence_pkg::core_resp_t [1:0] core_resp,
  output coherence_pkg::cc_out_t [1:0]    cc_out
);

  coherence_pkg::ram_req_t    ram_req;
  coherence_pkg::word_t       ramload;
  coherence_pkg::ramstate_t   ramstate;
  coherence_pkg::ctrl_state_t cstate;
  logic                       active_core;

  memory_control i_memory_control (
    .CLK         (CLK),
    .nRST        (nRST),
    .core_req    (core_req),
    .cc_in       (cc_in),
    .ramload     (ramload),
    .ramstate    (ramstate),
    .core_resp   (core_resp),
    .ram_req     (ram_req),
    .cstate      (cstate),
    .active_core (active_core)
  );

  snoop_router i_snoop_router (
    .cstate      (cstate),
    .active_core (active_core),
    .core_req    (core_req),
    .cc_in       (cc_in),
    .cc_out      (cc_out)
  );

  ram_model #(
    .RAM_LATENCY (RAM_LATENCY)
  ) i_ram_model (
    .CLK      (CLK),
    .nRST     (nRST),
    .ram_req  (ram_req),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

endmodule
`default_nettype wire

/* rtl/memory_control.sv */
`timescale 1ns/1ns
`default_nettype none
// --------------------------------------------------------------------
// memory controller
// arbitrates both cores onto the single RAM port and runs the snoopy
// coherence FSM: miss to RAM, cache-to-cache fetch, or write back
// then forward. A halted core holds everything off until flushed.
// --------------------------------------------------------------------
module memory_control (
  input  logic                            CLK,
  input  logic                            nRST,
  input  coherence_pkg::core_req_t [1:0]  core_req,
  input  coherence_pkg::cc_in_t [1:0]     cc_in,
  input  coherence_pkg::word_t            ramload,
  input  coherence_pkg::ramstate_t        ramstate,
  output coherence_pkg::core_resp_t [1:0] core_resp,
  output coherence_pkg::ram_req_t         ram_req,
  output coherence_pkg::ctrl_state_t      cstate,
  output logic                            active_core
);

  coherence_pkg::ctrl_state_t nstate;
  logic       next_active_core;
  logic       active;
  logic       next_active;
  logic       dataready;
  logic       next_dataready;
  logic       memtransfer;
  logic       next_memtransfer;
  logic       peer;
  logic [1:0] dreq;
  logic [1:0] ireq;
  logic [1:0] hold_off;
  logic       xfer_done;
  logic       fetch_ok;

  assign peer = ~active_core;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      dreq[i]     = (core_req[i].dREN | core_req[i].dWEN) & ~core_req[i].halted;
      ireq[i]     = core_req[i].iREN & ~core_req[i].halted;
      hold_off[i] = core_req[i].halted & ~core_req[i].flushed;
    end
  end

  // data transfer finishes on peer forward or on the RAM access cycle
  assign xfer_done = active & (dataready | (ramstate == coherence_pkg::ACCESS));

  // instruction fetches only run from IDLE and never during a pending halt
  assign fetch_ok = (cstate == coherence_pkg::IDLE) && (hold_off == 2'b00) &&
                    ireq[active_core];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cstate      <= coherence_pkg::IDLE;
      active_core <= 1'b0;
      active      <= 1'b0;
      dataready   <= 1'b0;
      memtransfer <= 1'b0;
    end else begin
      cstate      <= nstate;
      active_core <= next_active_core;
      active      <= next_active;
      dataready   <= next_dataready;
      memtransfer <= next_memtransfer;
    end
  end

  always_comb begin
    nstate           = cstate;
    next_active_core = active_core;
    next_active      = active;
    next_dataready   = dataready;
    next_memtransfer = memtransfer;

    case (cstate)
      coherence_pkg::IDLE: begin
        if (hold_off[0]) begin
          nstate           = coherence_pkg::HALT;
          next_active_core = 1'b0;
        end else if (hold_off[1]) begin
          nstate           = coherence_pkg::HALT;
          next_active_core = 1'b1;
        end else if (dreq != 2'b00) begin
          nstate = coherence_pkg::ARBITER;
        end else if (ireq[peer] &&
                     (!ireq[active_core] || (fetch_ok && ramstate == coherence_pkg::ACCESS))) begin
          // hand the port over after a finished fetch
          next_active_core = peer;
        end
      end

      coherence_pkg::ARBITER: begin
        // core 0 wins between data requests
        next_active_core = ~dreq[0];
        if (dreq == 2'b00) begin
          nstate = coherence_pkg::IDLE;
        end else if (core_req[~dreq[0]].evict) begin
          nstate      = coherence_pkg::EVICTION;
          next_active = 1'b1;
        end else begin
          nstate = coherence_pkg::SNOOP;
        end
      end

      coherence_pkg::SNOOP: begin
        next_active = 1'b1;
        // writes always land in RAM
        if (core_req[active_core].dWEN || !cc_in[peer].cctrans || core_req[peer].halted) begin
          nstate = coherence_pkg::MISS_0;
        end else if (cc_in[peer].ccwrite) begin
          nstate           = coherence_pkg::WRITE_BACK_0;
          next_memtransfer = 1'b1;
        end else begin
          nstate         = coherence_pkg::FETCH_CACHE_0;
          next_dataready = 1'b1;
        end
      end

      coherence_pkg::EVICTION, coherence_pkg::MISS_0: begin
        if (xfer_done) begin
          nstate      = coherence_pkg::MISS_1;
          next_active = 1'b0;
        end
      end

      coherence_pkg::WRITE_BACK_0: begin
        if (xfer_done) begin
          nstate           = coherence_pkg::WRITE_BACK_1;
          next_active      = 1'b0;
          next_memtransfer = 1'b0;
        end
      end

      coherence_pkg::FETCH_CACHE_0: begin
        nstate         = coherence_pkg::FETCH_CACHE_1;
        next_active    = 1'b0;
        next_dataready = 1'b0;
      end

      // turnaround cycle, the core changes its request here
      coherence_pkg::MISS_1, coherence_pkg::WRITE_BACK_1, coherence_pkg::FETCH_CACHE_1: begin
        nstate = coherence_pkg::IDLE;
      end

      coherence_pkg::HALT: begin
        if (core_req[active_core].flushed) begin
          nstate = coherence_pkg::IDLE;
        end
      end

      default: nstate = coherence_pkg::IDLE;
    endcase
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      core_resp[i].iwait = 1'b1;
      core_resp[i].dwait = 1'b1;
      core_resp[i].iload = ramload;
      core_resp[i].dload = ramload;
    end
    ram_req = '0;

    if (active) begin
      if (memtransfer) begin
        // dirty peer line goes to RAM and to the requester at once
        ram_req.ramWEN   = 1'b1;
        ram_req.ramaddr  = core_req[active_core].daddr;
        ram_req.ramstore = core_req[peer].dstore;
      end else if (!dataready) begin
        ram_req.ramWEN   = core_req[active_core].dWEN;
        ram_req.ramREN   = core_req[active_core].dREN & ~core_req[active_core].dWEN;
        ram_req.ramaddr  = core_req[active_core].daddr;
        ram_req.ramstore = core_req[active_core].dstore;
      end
      if (dataready || memtransfer) begin
        core_resp[active_core].dload = core_req[peer].dstore;
      end
      core_resp[active_core].dwait = ~xfer_done;
    end else if (fetch_ok) begin
      ram_req.ramREN               = 1'b1;
      ram_req.ramaddr              = core_req[active_core].iaddr;
      core_resp[active_core].iwait = (ramstate != coherence_pkg::ACCESS);
    end
  end

endmodule
`default_nettype wire

/* rtl/ram_model.sv */
`timescale 1ns/1ns
`default_nettype none
// --------------------------------------------------------------------
// RAM model
// 256-word memory with a fixed access latency; reports BUSY while a
// request is held and ACCESS for the one cycle it completes
// --------------------------------------------------------------------
module ram_model #(
  parameter int RAM_LATENCY = 2
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  coherence_pkg::ram_req_t   ram_req,
  output coherence_pkg::word_t      ramload,
  output coherence_pkg::ramstate_t  ramstate
);

  localparam int CW = $clog2(RAM_LATENCY + 1);

  coherence_pkg::word_t    mem [256];
  coherence_pkg::ram_req_t prev;
  logic                    held;
  logic                    same;
  logic [CW-1:0]           cnt;
  logic [CW-1:0]           cur_cnt;
  logic [7:0]              idx;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = coherence_pkg::word_t'(i);
    end
  end

  assign idx     = ram_req.ramaddr[9:2];
  assign ramload = mem[idx];

  // a new or changed request restarts the countdown
  assign same    = held && (ram_req == prev);
  assign cur_cnt = same ? cnt : CW'(RAM_LATENCY - 1);

  always_comb begin
    if (!ram_req.ramREN && !ram_req.ramWEN) begin
      ramstate = coherence_pkg::FREE;
    end else if (ram_req.ramREN && ram_req.ramWEN) begin
      ramstate = coherence_pkg::ERROR;
    end else if (cur_cnt == '0) begin
      ramstate = coherence_pkg::ACCESS;
    end else begin
      ramstate = coherence_pkg::BUSY;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      held <= 1'b0;
      cnt  <= '0;
    end else begin
      held <= (ramstate == coherence_pkg::BUSY);
      cnt  <= cur_cnt - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    prev <= ram_req;
    if (ramstate == coherence_pkg::ACCESS && ram_req.ramWEN) begin
      mem[idx] <= ram_req.ramstore;
    end
  end

endmodule
`default_nettype wire

/* rtl/snoop_router.sv */
`timescale 1ns/1ns
`default_nettype none
// --------------------------------------------------------------------
// snoop router
// points the peer cache at the requester's data address, holds the
// peer with ccwait while its line is used, and derives invalidates
// --------------------------------------------------------------------
module snoop_router (
  input  coherence_pkg::ctrl_state_t     cstate,
  input  logic                           active_core,
  input  coherence_pkg::core_req_t [1:0] core_req,
  input  coherence_pkg::cc_in_t [1:0]    cc_in,
  output coherence_pkg::cc_out_t [1:0]   cc_out
);

  logic peer;
  logic holding;
  logic addressed;

  assign peer = ~active_core;

  always_comb begin
    case (cstate)
      coherence_pkg::SNOOP,
      coherence_pkg::WRITE_BACK_0,
      coherence_pkg::WRITE_BACK_1,
      coherence_pkg::FETCH_CACHE_0,
      coherence_pkg::FETCH_CACHE_1: begin
        holding   = 1'b1;
        addressed = 1'b1;
      end
      // RAM paths only show the address
      coherence_pkg::MISS_0,
      coherence_pkg::MISS_1,
      coherence_pkg::EVICTION: begin
        holding   = 1'b0;
        addressed = 1'b1;
      end
      default: begin
        holding   = 1'b0;
        addressed = 1'b0;
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      cc_out[i].ccwait      = 1'b0;
      cc_out[i].ccinv       = cc_in[1 - i].cctrans & cc_in[1 - i].ccwrite;
      cc_out[i].ccsnoopaddr = '0;
    end
    if (addressed) begin
      cc_out[peer].ccsnoopaddr = core_req[active_core].daddr;
    end
    // a halted peer cannot answer
    if (holding) begin
      cc_out[peer].ccwait = ~core_req[peer].halted;
    end
  end

endmodule
`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module memory_control_tb -f verilog.f > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vmemory_control_tb > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verilog.f */
rtl/coherence_pkg.sv
rtl/memory_control.sv
rtl/snoop_router.sv
rtl/ram_model.sv
rtl/coherent_memory_top.sv
bench/memory_control_checker.sv
bench/memory_control_tb.sv
